//--- sources.f
logic/mem_pkg.sv
logic/rv_pkg.sv
logic/word_ram.sv
logic/mem_access.sv
logic/load_format.sv
logic/lsu_top.sv
sim/tb_lsu.sv

//--- Makefile
TOP = tb_lsu

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module $(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || echo "CHECKS FAILED" >> sim.log
	cat sim.log
	@if grep -q "CHECKS FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

//--- sim/tb_lsu.sv
// load/store unit testbench
`timescale 1ns/1ps

module tb_lsu;

  localparam int RAM_WORDS = 256;
  localparam int WIN_BYTES = RAM_WORDS * 8;
  // room for 900 accesses of up to 5 cycles plus reset and a margin
  localparam int WATCHDOG_NS = 900 * 5 * 20 + 10 * 20 + 2000;

  logic            clk;
  logic            rst_n;
  logic            req;
  logic            we;
  mem_pkg::addr_t  addr;
  rv_pkg::funct3_t funct3;
  mem_pkg::word_t  wdata;
  logic            busy;
  logic            done;
  logic            fault;
  mem_pkg::word_t  rdata;

  // reference copy of the window with one entry per byte
  logic [7:0] shadow [WIN_BYTES];

  integer seed;
  int     errors;
  int     checks;
  int     test_errors;

  lsu_top #(
    .RAM_WORDS(RAM_WORDS)
  ) u_dut (.*);

  always #10 clk = ~clk;

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("CHECKS FAILED");
    $finish;
  end

  function automatic mem_pkg::addr_t win_addr(input int rel);
    return mem_pkg::BASE_ADDR + mem_pkg::addr_t'(rel);
  endfunction

  // fill value mixes every bit of the word number
  function automatic mem_pkg::word_t fill_word(input int idx);
    return {idx * 32'h9e37_79b9, ~idx ^ 32'h5a5a_0f0f};
  endfunction

  // little-endian gather and then sign or zero fill above the access size
  function automatic mem_pkg::word_t expected_load(input int rel, input rv_pkg::funct3_t f3);
    mem_pkg::word_t val;
    int             nbytes;
    logic           neg;
    nbytes = 1 << f3[1:0];
    neg = !f3[2] && shadow[rel + nbytes - 1][7];
    val = '0;
    for (int i = 0; i < 8; i++) begin
      if (i < nbytes) begin
        val[i*8 +: 8] = shadow[rel + i];
      end else if (neg) begin
        val[i*8 +: 8] = 8'hff;
      end
    end
    return val;
  endfunction

  task automatic check_word(input string name, input mem_pkg::word_t exp,
                            input mem_pkg::word_t act);
    checks++;
    if (exp !== act) begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (exp !== act) begin
      $display("FAIL %s expected %b actual %b", name, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  // entered and left 2 ns after a rising edge
  task automatic do_access(input string name, input logic wr, input mem_pkg::addr_t a,
                           input rv_pkg::funct3_t f3, input mem_pkg::word_t wd,
                           output mem_pkg::word_t rd, output logic flt);
    int waited;
    waited = 0;
    while (busy) begin
      @(posedge clk);
      #2;
    end
    req = 1'b1;
    we = wr;
    addr = a;
    funct3 = f3;
    wdata = wd;
    @(posedge clk);
    #2;
    req = 1'b0;
    check_flag({name, " busy"}, 1'b1, busy);
    while (!done && waited < 16) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (!done) begin
      $display("%s: access to %h with funct3 %0d never raised done", name, a, f3);
      errors++;
      test_errors++;
    end
    rd = rdata;
    flt = fault;
    @(posedge clk);
    #2;
    check_flag({name, " idle"}, 1'b0, busy);
  endtask

  task automatic store_access(input string name, input mem_pkg::addr_t a,
                              input rv_pkg::funct3_t f3, input mem_pkg::word_t wd);
    mem_pkg::word_t rd;
    logic           flt;
    int             rel;
    do_access(name, 1'b1, a, f3, wd, rd, flt);
    check_flag({name, " fault"}, 1'b0, flt);
    check_word({name, " rdata"}, '0, rd);
    rel = int'(a - mem_pkg::BASE_ADDR);
    for (int i = 0; i < (1 << f3[1:0]); i++) begin
      shadow[rel + i] = wd[i*8 +: 8];
    end
  endtask

  task automatic load_access(input string name, input mem_pkg::addr_t a,
                             input rv_pkg::funct3_t f3);
    mem_pkg::word_t rd;
    logic           flt;
    do_access(name, 1'b0, a, f3, '0, rd, flt);
    check_flag({name, " fault"}, 1'b0, flt);
    check_word(name, expected_load(int'(a - mem_pkg::BASE_ADDR), f3), rd);
  endtask

  task automatic expect_fault(input string name, input logic wr, input mem_pkg::addr_t a,
                              input rv_pkg::funct3_t f3);
    mem_pkg::word_t rd;
    logic           flt;
    do_access(name, wr, a, f3, 64'hdead_beef_0bad_f00d, rd, flt);
    check_flag({name, " fault"}, 1'b1, flt);
    check_word({name, " rdata"}, '0, rd);
  endtask

  task automatic finish_test(input string name);
    $display("test %s finished with %0d errors", name, test_errors);
    test_errors = 0;
  endtask

  task automatic test_aligned_double();
    for (int i = 0; i < RAM_WORDS; i++) begin
      store_access("aligned_sd", win_addr(i * 8), 3'd3, fill_word(i));
    end
    for (int i = 0; i < RAM_WORDS; i++) begin
      load_access("aligned_ld", win_addr(i * 8), rv_pkg::FUNCT3_LD);
    end
    finish_test("aligned_double");
  endtask

  task automatic test_sign_extend();
    // top bits set at offset 0 and mixed at offset 4
    store_access("sext_sd", win_addr('h100), 3'd3, 64'h7f01_80ff_8765_c3f1);
    for (int off = 0; off < 8; off += 4) begin
      for (int f = 0; f < 7; f++) begin
        load_access("sext_ld", win_addr('h100 + off), rv_pkg::funct3_t'(f));
      end
    end
    finish_test("sign_extend");
  endtask

  task automatic test_straddle();
    store_access("sh_cross", win_addr('h207), 3'd1, 64'hdead_beef_cafe_a55a);
    store_access("sw_cross", win_addr('h20d), 3'd2, 64'h1357_2468_9abc_def0);
    store_access("sd_cross", win_addr('h223), 3'd3, 64'h0123_4567_89ab_cdef);
    load_access("lh_cross", win_addr('h207), rv_pkg::FUNCT3_LH);
    load_access("lhu_cross", win_addr('h207), rv_pkg::FUNCT3_LHU);
    load_access("lw_cross", win_addr('h20d), rv_pkg::FUNCT3_LW);
    load_access("lwu_cross", win_addr('h20d), rv_pkg::FUNCT3_LWU);
    load_access("ld_cross", win_addr('h223), rv_pkg::FUNCT3_LD);
    for (int w = 'h200; w < 'h230; w += 8) begin
      load_access("cross_neighbor", win_addr(w), rv_pkg::FUNCT3_LD);
    end
    finish_test("straddle");
  endtask

  task automatic test_sub_word();
    store_access("sb_lane", win_addr('h301), 3'd0, 64'h1122_3344_5566_77e8);
    store_access("sh_lane", win_addr('h30a), 3'd1, 64'h99aa_bbcc_ddee_0f1e);
    store_access("sw_lane", win_addr('h314), 3'd2, 64'hffff_0000_2d3c_4b5a);
    for (int w = 'h300; w < 'h320; w += 8) begin
      load_access("sub_word_ld", win_addr(w), rv_pkg::FUNCT3_LD);
    end
    finish_test("sub_word");
  endtask

  task automatic test_faults();
    expect_fault("ld_below", 1'b0, mem_pkg::BASE_ADDR - 64'd8, rv_pkg::FUNCT3_LD);
    expect_fault("sb_below", 1'b1, mem_pkg::BASE_ADDR - 64'd1, 3'd0);
    expect_fault("lb_past", 1'b0, win_addr(WIN_BYTES), rv_pkg::FUNCT3_LB);
    expect_fault("sd_past_end", 1'b1, win_addr(WIN_BYTES - 4), 3'd3);
    expect_fault("ld_high", 1'b0, 64'hffff_ffff_ffff_fff8, rv_pkg::FUNCT3_LD);
    expect_fault("load_funct3_7", 1'b0, win_addr('h400), 3'd7);
    expect_fault("store_funct3_4", 1'b1, win_addr('h400), 3'd4);
    expect_fault("store_funct3_7", 1'b1, win_addr('h408), 3'd7);
    // memory behind the faulting stores is still the fill pattern
    load_access("after_fault_400", win_addr('h400), rv_pkg::FUNCT3_LD);
    load_access("after_fault_408", win_addr('h408), rv_pkg::FUNCT3_LD);
    load_access("after_fault_last", win_addr(WIN_BYTES - 8), rv_pkg::FUNCT3_LD);
    load_access("last_byte", win_addr(WIN_BYTES - 1), rv_pkg::FUNCT3_LBU);
    finish_test("faults");
  endtask

  task automatic test_random_mix(input int count);
    logic [31:0]     r;
    logic            wr;
    rv_pkg::funct3_t f3;
    int              nbytes;
    int              rel;
    mem_pkg::word_t  wd;
    for (int n = 0; n < count; n++) begin
      r = $random(seed);
      wr = r[0];
      // unsigned variant only below double size
      f3 = {!wr && r[3] && (r[2:1] != 2'd3), r[2:1]};
      nbytes = 1 << f3[1:0];
      rel = int'(r[30:4]) % (WIN_BYTES - nbytes + 1);
      wd = {$random(seed), $random(seed)};
      if (wr) begin
        store_access("random_store", win_addr(rel), f3, wd);
      end else begin
        load_access("random_load", win_addr(rel), f3);
      end
    end
    finish_test("random_mix");
  endtask

  initial begin
    seed = 32'h73f5_39d1;
    errors = 0;
    checks = 0;
    test_errors = 0;
    clk = 1'b0;
    rst_n = 1'b0;
    req = 1'b0;
    we = 1'b0;
    addr = '0;
    funct3 = '0;
    wdata = '0;
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
    test_aligned_double();
    test_sign_extend();
    test_straddle();
    test_sub_word();
    test_faults();
    test_random_mix(200);
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- logic/lsu_top.sv
// load/store unit top
`timescale 1ns/1ps

module lsu_top #(
  parameter int RAM_WORDS = 256
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            req,
  input  logic            we,
  input  mem_pkg::addr_t  addr,
  input  rv_pkg::funct3_t funct3,
  input  mem_pkg::word_t  wdata,
  output logic            busy,
  output logic            done,
  output logic            fault,
  output mem_pkg::word_t  rdata
);

  logic                 load_valid;
  rv_pkg::funct3_t      fmt_funct3;
  mem_pkg::word_t       raw_data;

  // RAM side
  logic                 ram_en;
  logic                 ram_we;
  mem_pkg::word_index_t ram_index;
  mem_pkg::word_t       ram_wdata;
  mem_pkg::byte_mask_t  ram_mask;
  mem_pkg::word_t       ram_rdata;

  mem_access #(
    .RAM_WORDS(RAM_WORDS)
  ) u_mem_access (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .we         (we),
    .addr       (addr),
    .funct3     (funct3),
    .wdata      (wdata),
    .busy       (busy),
    .done       (done),
    .fault      (fault),
    .load_valid (load_valid),
    .fmt_funct3 (fmt_funct3),
    .raw_data   (raw_data),
    .ram_en     (ram_en),
    .ram_we     (ram_we),
    .ram_index  (ram_index),
    .ram_wdata  (ram_wdata),
    .ram_mask   (ram_mask),
    .ram_rdata  (ram_rdata)
  );

  load_format u_load_format (
    .ren      (load_valid),
    .funct3   (fmt_funct3),
    .raw_data (raw_data),
    .rdata    (rdata)
  );

  word_ram #(
    .RAM_WORDS(RAM_WORDS)
  ) u_word_ram (
    .clk   (clk),
    .en    (ram_en),
    .we    (ram_we),
    .index (ram_index),
    .wdata (ram_wdata),
    .mask  (ram_mask),
    .rdata (ram_rdata)
  );

endmodule

//--- logic/load_format.sv
// load data extension
`timescale 1ns/1ps

module load_format (
  input  logic            ren,
  input  rv_pkg::funct3_t funct3,
  input  mem_pkg::word_t  raw_data,
  output mem_pkg::word_t  rdata
);

  always_comb begin
    rdata = '0;
    if (ren) begin
      case (funct3)
        // signed loads
        rv_pkg::FUNCT3_LB:  rdata = {{56{raw_data[7]}}, raw_data[7:0]};
        rv_pkg::FUNCT3_LH:  rdata = {{48{raw_data[15]}}, raw_data[15:0]};
        rv_pkg::FUNCT3_LW:  rdata = {{32{raw_data[31]}}, raw_data[31:0]};
        rv_pkg::FUNCT3_LD:  rdata = raw_data;
        // unsigned loads
        rv_pkg::FUNCT3_LBU: rdata = {56'd0, raw_data[7:0]};
        rv_pkg::FUNCT3_LHU: rdata = {48'd0, raw_data[15:0]};
        rv_pkg::FUNCT3_LWU: rdata = {32'd0, raw_data[31:0]};
        default:            rdata = '0;
      endcase
    end
  end

endmodule

//--- logic/mem_access.sv
// access splitter and merger
`timescale 1ns/1ps

module mem_access #(
  parameter int RAM_WORDS = 256
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 req,
  input  logic                 we,
  input  mem_pkg::addr_t       addr,
  input  rv_pkg::funct3_t      funct3,
  input  mem_pkg::word_t       wdata,
  output logic                 busy,
  output logic                 done,
  output logic                 fault,
  output logic                 load_valid,
  output rv_pkg::funct3_t      fmt_funct3,
  output mem_pkg::word_t       raw_data,
  output logic                 ram_en,
  output logic                 ram_we,
  output mem_pkg::word_index_t ram_index,
  output mem_pkg::word_t       ram_wdata,
  output mem_pkg::byte_mask_t  ram_mask,
  input  mem_pkg::word_t       ram_rdata
);

  typedef enum logic [1:0] {IDLE, UNIT1, UNIT2, FINISH} state_t;

  // window size in bytes
  localparam mem_pkg::addr_t WIN_BYTES = mem_pkg::addr_t'(RAM_WORDS) << 3;

  state_t state;

  logic           accept;
  logic [3:0]     req_bytes;
  mem_pkg::addr_t req_rel;
  logic           req_straddle;
  logic           req_fault;

  // captured access
  logic                 we_q;
  logic                 fault_q;
  logic                 straddle_q;
  rv_pkg::funct3_t      funct3_q;
  mem_pkg::word_index_t index_q;
  mem_pkg::byte_off_t   off_q;
  mem_pkg::word_t       wdata_q;

  // read words with the low word first
  mem_pkg::word_t rd_lo;
  mem_pkg::word_t rd_hi;

  rv_pkg::size_t size_q;
  logic [7:0]    size_lanes;
  logic [15:0]   lanes_wide;
  logic [127:0]  wdata_wide;
  logic [127:0]  rdata_wide;
  logic [5:0]    bit_off;

  assign busy   = (state != IDLE) || done;
  assign accept = req && !busy;

  assign req_bytes    = 4'd1 << funct3[1:0];
  assign req_rel      = addr - mem_pkg::BASE_ADDR;
  assign req_straddle = ({1'b0, addr[2:0]} + req_bytes) > 4'd8;

  // outside the window or illegal for the direction
  assign req_fault = (addr < mem_pkg::BASE_ADDR)
                  || (req_rel > WIN_BYTES - mem_pkg::addr_t'(req_bytes))
                  || (!we && funct3 == 3'd7)
                  || (we && funct3[2]);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= IDLE;
      done    <= 1'b0;
      fault_q <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        IDLE: begin
          if (accept) begin
            fault_q <= req_fault;
            // faults skip the RAM entirely
            state   <= req_fault ? FINISH : UNIT1;
          end
        end
        UNIT1: state <= straddle_q ? UNIT2 : FINISH;
        UNIT2: state <= FINISH;
        FINISH: begin
          state <= IDLE;
          done  <= 1'b1;
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      we_q       <= we;
      funct3_q   <= funct3;
      index_q    <= req_rel >> 3;
      off_q      <= addr[2:0];
      straddle_q <= req_straddle;
      wdata_q    <= wdata;
    end
    // first word arrives while in UNIT2 on a straddle
    if (state == UNIT2) begin
      rd_lo <= ram_rdata;
    end
    if (state == FINISH) begin
      if (straddle_q) begin
        rd_hi <= ram_rdata;
      end else begin
        rd_lo <= ram_rdata;
      end
    end
  end

  assign size_q  = funct3_q[1:0];
  assign bit_off = {off_q, 3'b000};

  always_comb begin
    case (size_q)
      2'd0:    size_lanes = 8'h01;
      2'd1:    size_lanes = 8'h03;
      2'd2:    size_lanes = 8'h0f;
      default: size_lanes = 8'hff;
    endcase
  end

  // store data and lanes spread across two words
  assign lanes_wide = {8'h00, size_lanes} << off_q;
  assign wdata_wide = {64'd0, wdata_q} << bit_off;

  assign ram_en    = (state == UNIT1) || (state == UNIT2);
  assign ram_we    = ram_en && we_q;
  assign ram_index = (state == UNIT2) ? index_q + 1'b1 : index_q;
  assign ram_wdata = (state == UNIT2) ? wdata_wide[127:64] : wdata_wide[63:0];
  assign ram_mask  = (state == UNIT2) ? lanes_wide[15:8] : lanes_wide[7:0];

  // merge the two words and use the high one only on a straddle
  assign rdata_wide = {(straddle_q ? rd_hi : 64'd0), rd_lo} >> bit_off;
  assign raw_data   = rdata_wide[63:0];

  assign fault      = done && fault_q;
  assign load_valid = done && !we_q && !fault_q;
  assign fmt_funct3 = funct3_q;

  a_req_idle_only: assert property (
    @(posedge clk) disable iff (!rst_n) !(req && busy)
  );

  a_done_pulse: assert property (
    @(posedge clk) disable iff (!rst_n) done |=> !done
  );

  a_no_ram_in_idle: assert property (
    @(posedge clk) disable iff (!rst_n) (state == IDLE) |-> !ram_en
  );

endmodule

//--- logic/word_ram.sv
// byte-masked word RAM
`timescale 1ns/1ps

module word_ram #(
  parameter int RAM_WORDS = 256
) (
  input  logic                 clk,
  input  logic                 en,
  input  logic                 we,
  input  mem_pkg::word_index_t index,
  input  mem_pkg::word_t       wdata,
  input  mem_pkg::byte_mask_t  mask,
  output mem_pkg::word_t       rdata
);

  localparam int IDX_W = $clog2(RAM_WORDS);

  mem_pkg::word_t mem [RAM_WORDS];

  logic [IDX_W-1:0] row;

  // upper index bits are guaranteed zero by the window check
  assign row = index[IDX_W-1:0];

  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        for (int lane = 0; lane < 8; lane++) begin
          if (mask[lane]) begin
            mem[row][lane*8 +: 8] <= wdata[lane*8 +: 8];
          end
        end
      end
      // read-before-write on the same row
      rdata <= mem[row];
    end
  end

  a_index_in_range: assert property (
    @(posedge clk) en |-> index < mem_pkg::word_index_t'(RAM_WORDS)
  );

endmodule

//--- logic/rv_pkg.sv
// load/store encodings
package rv_pkg;

  typedef logic [2:0] funct3_t;

  // access size taken from funct3[1:0] (byte, half, word, double)
  typedef logic [1:0] size_t;

  // load encodings
  localparam funct3_t FUNCT3_LB  = 3'b000;
  localparam funct3_t FUNCT3_LH  = 3'b001;
  localparam funct3_t FUNCT3_LW  = 3'b010;
  localparam funct3_t FUNCT3_LD  = 3'b011;
  localparam funct3_t FUNCT3_LBU = 3'b100;
  localparam funct3_t FUNCT3_LHU = 3'b101;
  localparam funct3_t FUNCT3_LWU = 3'b110;

  // stores reuse 0..3 (SB, SH, SW, SD) and never set bit 2

endpackage

//--- logic/mem_pkg.sv
// memory geometry definitions
package mem_pkg;

  // byte address as seen by the core
  typedef logic [63:0] addr_t;

  // one RAM word of eight byte lanes
  typedef logic [63:0] word_t;

  // one enable bit per byte lane
  typedef logic [7:0] byte_mask_t;

  // byte position inside a word
  typedef logic [2:0] byte_off_t;

  // aligned word number counted from the window base
  typedef logic [63:0] word_index_t;

  // first byte of the RAM window
  localparam addr_t BASE_ADDR = 64'h8000_0000;

endpackage
